// ==== source/send_recv_params.svh ====
`ifndef SEND_RECV_PARAMS_SVH
`define SEND_RECV_PARAMS_SVH

// ---------------------------------------------------------------------------
// axi4-lite control port
// ---------------------------------------------------------------------------

// data word of the register slave
`define AXIL_DATA_BITS 32

// byte address, 15 words of 4 bytes
`define AXIL_ADDR_BITS 6

// registers in the map
`define N_REGS 15

// ---------------------------------------------------------------------------
// network streams
// ---------------------------------------------------------------------------

`define STREAM_BITS 64  // one header or one payload word

`endif

// ==== source/send_recv_axil_pkg.sv ====
`default_nettype none

package send_recv_axil_pkg;

  // word index of each register, byte address is index * 4
  localparam int REG_CTRL      = 0;   // wo, bit 0 starts a run
  localparam int REG_STATUS    = 1;   // ro, bit 0 done
  localparam int REG_USE_CONN  = 2;
  localparam int REG_USE_IP    = 3;   // nonzero steps ip per connection
  localparam int REG_PKG_WORDS = 4;   // payload words per packet
  localparam int REG_BASE_PORT = 5;
  localparam int REG_BASE_IP   = 6;
  localparam int REG_XFER_SIZE = 7;   // bytes
  localparam int REG_IS_SERVER = 8;
  localparam int REG_TIME_SEC  = 9;   // stored only
  localparam int REG_TIME_CYC  = 10;  // 0 means no limit

  // live counters, low word only
  localparam int REG_EXEC_CYC  = 11;
  localparam int REG_CONSUMED  = 12;
  localparam int REG_PRODUCED  = 13;
  localparam int REG_OPEN_CYC  = 14;

  // write and read response
  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== source/send_recv_stream_pkg.sv ====
`default_nettype none

`include "send_recv_params.svh"

package send_recv_stream_pkg;

  // single-word packet header, msb first
  typedef struct packed {
    logic [31:0] ip;
    logic [15:0] port;
    logic [15:0] len;   // payload bytes behind it, 0 opens a connection
  } stream_hdr_t;

  // a stream word is read either as header or as raw payload
  typedef union packed {
    stream_hdr_t               hdr;
    logic [`STREAM_BITS-1:0]   payload;
  } stream_word_u;

endpackage

`default_nettype wire

// ==== source/send_recv_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "send_recv_params.svh"

module send_recv_slave (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic [`AXIL_ADDR_BITS-1:0]    s_axil_awaddr,
  input  logic                          s_axil_awvalid,
  output logic                          s_axil_awready,
  input  logic [`AXIL_DATA_BITS-1:0]    s_axil_wdata,
  input  logic [`AXIL_DATA_BITS/8-1:0]  s_axil_wstrb,
  input  logic                          s_axil_wvalid,
  output logic                          s_axil_wready,
  output logic [1:0]                    s_axil_bresp,
  output logic                          s_axil_bvalid,
  input  logic                          s_axil_bready,
  input  logic [`AXIL_ADDR_BITS-1:0]    s_axil_araddr,
  input  logic                          s_axil_arvalid,
  output logic                          s_axil_arready,
  output logic [`AXIL_DATA_BITS-1:0]    s_axil_rdata,
  output logic [1:0]                    s_axil_rresp,
  output logic                          s_axil_rvalid,
  input  logic                          s_axil_rready,
  output logic                          ap_start,
  input  logic                          ap_done,
  output logic [31:0]                   use_conn,
  output logic [31:0]                   use_ip,
  output logic [31:0]                   pkg_words,
  output logic [31:0]                   base_port,
  output logic [31:0]                   base_ip,
  output logic [31:0]                   xfer_size,
  output logic [31:0]                   is_server,
  output logic [63:0]                   time_cyc,
  input  logic [63:0]                   execution_cycles,
  input  logic [63:0]                   consumed_bytes,
  input  logic [63:0]                   produced_bytes,
  input  logic [63:0]                   open_con_cycles
);

  localparam int ADDR_LSB = $clog2(`AXIL_DATA_BITS/8);
  localparam int IDX_BITS = $clog2(`N_REGS);
  localparam int FIRST_RW = send_recv_axil_pkg::REG_USE_CONN;
  localparam int LAST_RW  = send_recv_axil_pkg::REG_TIME_CYC;

  logic [LAST_RW:FIRST_RW][`AXIL_DATA_BITS-1:0] cfg_q;  // rw block 2..10
  logic                                         start_q;
  logic                                         aw_en;
  logic                                         wr_en;
  logic                                         rd_en;
  logic [IDX_BITS-1:0]                          wr_idx;
  logic [IDX_BITS-1:0]                          rd_idx;

  assign wr_idx = s_axil_awaddr[ADDR_LSB +: IDX_BITS];
  assign rd_idx = s_axil_araddr[ADDR_LSB +: IDX_BITS];
  assign wr_en  = s_axil_awready && s_axil_awvalid && s_axil_wready && s_axil_wvalid;
  assign rd_en  = s_axil_arready && s_axil_arvalid && !s_axil_rvalid;

  // ---------------------------------------------------------------------------
  // register file
  // ---------------------------------------------------------------------------

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      start_q <= 1'b0;
      cfg_q   <= '0;
    end else begin
      start_q <= 1'b0;  // start bit clears itself
      if (wr_en) begin
        if (wr_idx == send_recv_axil_pkg::REG_CTRL && s_axil_wstrb[0]) begin
          start_q <= s_axil_wdata[0];
        end
        for (int r = FIRST_RW; r <= LAST_RW; r++) begin
          for (int b = 0; b < `AXIL_DATA_BITS/8; b++) begin
            if (wr_idx == r && s_axil_wstrb[b]) begin
              cfg_q[r][b*8 +: 8] <= s_axil_wdata[b*8 +: 8];
            end
          end
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_en) begin
      s_axil_rdata <= '0;  // holes read zero
      case (rd_idx)
        send_recv_axil_pkg::REG_STATUS:   s_axil_rdata[0] <= ap_done;
        send_recv_axil_pkg::REG_EXEC_CYC: s_axil_rdata <= execution_cycles[31:0];
        send_recv_axil_pkg::REG_CONSUMED: s_axil_rdata <= consumed_bytes[31:0];
        send_recv_axil_pkg::REG_PRODUCED: s_axil_rdata <= produced_bytes[31:0];
        send_recv_axil_pkg::REG_OPEN_CYC: s_axil_rdata <= open_con_cycles[31:0];
        default: begin
          if (rd_idx >= FIRST_RW && rd_idx <= LAST_RW) begin
            s_axil_rdata <= cfg_q[rd_idx];
          end
        end
      endcase
    end
  end

  assign ap_start  = start_q;
  assign use_conn  = cfg_q[send_recv_axil_pkg::REG_USE_CONN];
  assign use_ip    = cfg_q[send_recv_axil_pkg::REG_USE_IP];
  assign pkg_words = cfg_q[send_recv_axil_pkg::REG_PKG_WORDS];
  assign base_port = cfg_q[send_recv_axil_pkg::REG_BASE_PORT];
  assign base_ip   = cfg_q[send_recv_axil_pkg::REG_BASE_IP];
  assign xfer_size = cfg_q[send_recv_axil_pkg::REG_XFER_SIZE];
  assign is_server = cfg_q[send_recv_axil_pkg::REG_IS_SERVER];
  assign time_cyc  = {32'd0, cfg_q[send_recv_axil_pkg::REG_TIME_CYC]};

  // ---------------------------------------------------------------------------
  // axi4-lite handshake
  // ---------------------------------------------------------------------------

  assign s_axil_bresp = send_recv_axil_pkg::RESP_OKAY;
  assign s_axil_rresp = send_recv_axil_pkg::RESP_OKAY;

  // aw and w accepted together, one write in flight
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      s_axil_awready <= 1'b0;
      s_axil_wready  <= 1'b0;
      aw_en          <= 1'b1;
    end else if (!s_axil_awready && s_axil_awvalid && s_axil_wvalid && aw_en) begin
      s_axil_awready <= 1'b1;
      s_axil_wready  <= 1'b1;
      aw_en          <= 1'b0;
    end else begin
      s_axil_awready <= 1'b0;
      s_axil_wready  <= 1'b0;
      if (s_axil_bready && s_axil_bvalid) begin
        aw_en <= 1'b1;  // response done, next write may start
      end
    end
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      s_axil_bvalid  <= 1'b0;
      s_axil_arready <= 1'b0;
      s_axil_rvalid  <= 1'b0;
    end else begin
      if (wr_en && !s_axil_bvalid) begin
        s_axil_bvalid <= 1'b1;
      end else if (s_axil_bready && s_axil_bvalid) begin
        s_axil_bvalid <= 1'b0;
      end
      s_axil_arready <= !s_axil_arready && s_axil_arvalid && !s_axil_rvalid;
      if (rd_en) begin
        s_axil_rvalid <= 1'b1;
      end else if (s_axil_rvalid && s_axil_rready) begin
        s_axil_rvalid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/send_recv_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module send_recv_ctrl (
  input  logic        aclk,
  input  logic        aresetn,
  input  logic        ap_start,
  input  logic [31:0] is_server,
  input  logic [63:0] time_cyc,
  input  logic        tx_done,    // last word of a client run
  input  logic        rx_done,    // target reached on rx
  input  logic        opening,
  output logic        running,
  output logic        ap_done,
  output logic [63:0] execution_cycles,
  output logic [63:0] open_con_cycles
);

  localparam logic S_IDLE = 1'b0;
  localparam logic S_RUN  = 1'b1;

  logic        state_q;
  logic        done_q;
  logic [63:0] exec_q;
  logic [63:0] open_q;
  logic        role_done;
  logic        limit_hit;
  logic        run_end;

  assign running   = (state_q == S_RUN);
  assign role_done = (is_server == 32'd0) ? tx_done : rx_done;

  // this cycle is the time_cyc-th one of the run
  assign limit_hit = (time_cyc != 64'd0) && (exec_q + 64'd1 == time_cyc);
  assign run_end   = role_done || limit_hit;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state_q <= S_IDLE;
      done_q  <= 1'b0;
      exec_q  <= '0;
      open_q  <= '0;
    end else if (ap_start) begin
      state_q <= S_RUN;  // a new start restarts everything
      done_q  <= 1'b0;
      exec_q  <= '0;
      open_q  <= '0;
    end else if (running) begin
      exec_q <= exec_q + 64'd1;
      if (opening) begin
        open_q <= open_q + 64'd1;
      end
      if (run_end) begin
        state_q <= S_IDLE;
        done_q  <= 1'b1;  // held until next start
      end
    end
  end

  assign ap_done          = done_q;
  assign execution_cycles = exec_q;
  assign open_con_cycles  = open_q;

endmodule

`default_nettype wire

// ==== source/send_recv_sender.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "send_recv_params.svh"

module send_recv_sender (
  input  logic                     aclk,
  input  logic                     aresetn,
  input  logic                     ap_start,
  input  logic                     running,
  input  logic [31:0]              is_server,
  input  logic [31:0]              use_conn,
  input  logic [31:0]              use_ip,
  input  logic [31:0]              pkg_words,
  input  logic [31:0]              base_port,
  input  logic [31:0]              base_ip,
  input  logic [31:0]              xfer_size,
  output logic                     tx_valid,
  output logic [`STREAM_BITS-1:0]  tx_data,
  output logic                     tx_last,
  output logic                     opening,
  output logic                     tx_done,
  output logic [63:0]              produced_bytes
);

  localparam logic [1:0] PH_IDLE = 2'd0;
  localparam logic [1:0] PH_OPEN = 2'd1;
  localparam logic [1:0] PH_HDR  = 2'd2;
  localparam logic [1:0] PH_PAY  = 2'd3;

  logic [1:0]  phase_q;
  logic [31:0] conn_q;     // open index, then connection of current packet
  logic [31:0] word_q;     // payload word inside the packet
  logic [63:0] pay_q;      // payload words of the run, also the payload value
  logic        conn_wrap;
  logic        pkt_end;
  logic        xfer_end;
  logic [31:0] pkt_bytes;
  send_recv_stream_pkg::stream_word_u word;

  assign conn_wrap = (conn_q + 32'd1 >= use_conn);
  assign pkt_end   = (phase_q == PH_PAY) && (word_q + 32'd1 >= pkg_words);
  assign xfer_end  = ((pay_q + 64'd1) << 3) >= {32'd0, xfer_size};
  assign pkt_bytes = pkg_words << 3;

  always_comb begin
    word = '0;
    if (phase_q == PH_PAY) begin
      word.payload = pay_q;
    end else begin
      word.hdr.ip   = (use_ip != 32'd0) ? base_ip + conn_q : base_ip;
      word.hdr.port = base_port[15:0] + conn_q[15:0];
      word.hdr.len  = (phase_q == PH_HDR) ? pkt_bytes[15:0] : 16'd0;  // open hdr is empty
    end
  end

  // outputs drop with running, so a cycle limit cuts the stream at once
  assign tx_valid       = running && (phase_q != PH_IDLE);
  assign tx_data        = word;
  assign tx_last        = running && pkt_end;
  assign tx_done        = running && pkt_end && xfer_end;
  assign opening        = running && (phase_q == PH_OPEN);
  assign produced_bytes = pay_q << 3;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      phase_q <= PH_IDLE;
      conn_q  <= '0;
      word_q  <= '0;
      pay_q   <= '0;
    end else if (ap_start) begin
      phase_q <= (is_server == 32'd0) ? PH_OPEN : PH_IDLE;
      conn_q  <= '0;
      word_q  <= '0;
      pay_q   <= '0;
    end else if (running) begin
      case (phase_q)
        PH_OPEN: begin
          conn_q <= conn_wrap ? 32'd0 : conn_q + 32'd1;
          if (conn_wrap) begin
            phase_q <= PH_HDR;
          end
        end
        PH_HDR: begin
          word_q  <= '0;
          phase_q <= PH_PAY;
        end
        PH_PAY: begin
          pay_q  <= pay_q + 64'd1;
          word_q <= word_q + 32'd1;
          if (pkt_end) begin
            conn_q  <= conn_wrap ? 32'd0 : conn_q + 32'd1;  // round robin
            phase_q <= xfer_end ? PH_IDLE : PH_HDR;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/send_recv_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "send_recv_params.svh"

module send_recv_receiver (
  input  logic                     aclk,
  input  logic                     aresetn,
  input  logic                     ap_start,
  input  logic                     running,
  input  logic [31:0]              is_server,
  input  logic [31:0]              xfer_size,
  input  logic                     rx_valid,
  input  logic [`STREAM_BITS-1:0]  rx_data,
  input  logic                     rx_last,
  output logic                     rx_done,
  output logic [63:0]              consumed_bytes
);

  logic        in_payload_q;  // low while a header is expected
  logic [63:0] consumed_q;
  logic [63:0] consumed_next;
  logic        pay_word;
  send_recv_stream_pkg::stream_word_u rx_word;

  assign rx_word       = rx_data;
  assign pay_word      = running && rx_valid && in_payload_q;
  assign consumed_next = consumed_q + 64'd8;

  // only the server role ends a run on received bytes
  assign rx_done = pay_word && (is_server != 32'd0) &&
                   (consumed_next >= {32'd0, xfer_size});

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      in_payload_q <= 1'b0;
      consumed_q   <= '0;
    end else if (ap_start) begin
      in_payload_q <= 1'b0;  // first word after start is a header
      consumed_q   <= '0;
    end else if (running && rx_valid) begin
      if (rx_last) begin
        in_payload_q <= 1'b0;
      end else if (!in_payload_q) begin
        // zero length means a connection open, next word is a header again
        in_payload_q <= (rx_word.hdr.len != 16'd0);
      end
      if (in_payload_q) begin
        consumed_q <= consumed_next;
      end
    end
  end

  assign consumed_bytes = consumed_q;

endmodule

`default_nettype wire

// ==== source/send_recv_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "send_recv_params.svh"

module send_recv_top (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic [`AXIL_ADDR_BITS-1:0]    s_axil_awaddr,
  input  logic                          s_axil_awvalid,
  output logic                          s_axil_awready,
  input  logic [`AXIL_DATA_BITS-1:0]    s_axil_wdata,
  input  logic [`AXIL_DATA_BITS/8-1:0]  s_axil_wstrb,
  input  logic                          s_axil_wvalid,
  output logic                          s_axil_wready,
  output logic [1:0]                    s_axil_bresp,
  output logic                          s_axil_bvalid,
  input  logic                          s_axil_bready,
  input  logic [`AXIL_ADDR_BITS-1:0]    s_axil_araddr,
  input  logic                          s_axil_arvalid,
  output logic                          s_axil_arready,
  output logic [`AXIL_DATA_BITS-1:0]    s_axil_rdata,
  output logic [1:0]                    s_axil_rresp,
  output logic                          s_axil_rvalid,
  input  logic                          s_axil_rready,
  output logic                          tx_valid,
  output logic [`STREAM_BITS-1:0]       tx_data,
  output logic                          tx_last,
  input  logic                          rx_valid,
  input  logic [`STREAM_BITS-1:0]       rx_data,
  input  logic                          rx_last
);

  // configuration from the register file
  logic        ap_start;
  logic [31:0] use_conn;
  logic [31:0] use_ip;
  logic [31:0] pkg_words;
  logic [31:0] base_port;
  logic [31:0] base_ip;
  logic [31:0] xfer_size;
  logic [31:0] is_server;
  logic [63:0] time_cyc;

  // run status and counters
  logic        ap_done;
  logic        running;
  logic        opening;
  logic        tx_done;
  logic        rx_done;
  logic [63:0] execution_cycles;
  logic [63:0] open_con_cycles;
  logic [63:0] produced_bytes;
  logic [63:0] consumed_bytes;

  // port names match the nets above one to one
  send_recv_slave    u_slave    (.*);
  send_recv_ctrl     u_ctrl     (.*);
  send_recv_sender   u_sender   (.*);
  send_recv_receiver u_receiver (.*);

endmodule

`default_nettype wire

// ==== dv/send_recv_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module send_recv_chk (
  input logic aclk,
  input logic aresetn,
  input logic ap_start,
  input logic s_axil_bvalid,
  input logic s_axil_bready,
  input logic s_axil_rvalid,
  input logic s_axil_rready,
  input logic tx_valid,
  input logic running,
  input logic ap_done
);

  start_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
    ap_start |=> !ap_start)
    else $error("ap_start stayed high for more than one cycle");

  // responses wait for the master
  bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
    else $error("rvalid dropped before rready");

  tx_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
    !running |-> !tx_valid)
    else $error("tx_valid high outside a run");

  done_idle: assert property (@(posedge aclk) disable iff (!aresetn)
    running |-> !ap_done)
    else $error("done set while running");

endmodule

bind send_recv_top send_recv_chk u_chk (
  .aclk          (aclk),
  .aresetn       (aresetn),
  .ap_start      (ap_start),
  .s_axil_bvalid (s_axil_bvalid),
  .s_axil_bready (s_axil_bready),
  .s_axil_rvalid (s_axil_rvalid),
  .s_axil_rready (s_axil_rready),
  .tx_valid      (tx_valid),
  .running       (running),
  .ap_done       (ap_done)
);

`default_nettype wire

// ==== dv/send_recv_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "send_recv_params.svh"

module send_recv_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 10;
  localparam int HS_LIMIT     = 16;   // cycles allowed for one handshake
  localparam int DONE_POLLS   = 64;
  localparam int AXI_OPS      = 160;  // upper bound over all tests
  localparam int OP_CYCLES    = 6;
  localparam int RUN_CYCLES   = 400;  // stream cycles of the three runs
  localparam int TEST_CYCLES  = RESET_CYCLES + AXI_OPS * OP_CYCLES + RUN_CYCLES;

  logic                          aclk;
  logic                          aresetn;
  logic [`AXIL_ADDR_BITS-1:0]    s_axil_awaddr;
  logic                          s_axil_awvalid;
  logic                          s_axil_awready;
  logic [`AXIL_DATA_BITS-1:0]    s_axil_wdata;
  logic [`AXIL_DATA_BITS/8-1:0]  s_axil_wstrb;
  logic                          s_axil_wvalid;
  logic                          s_axil_wready;
  logic [1:0]                    s_axil_bresp;
  logic                          s_axil_bvalid;
  logic                          s_axil_bready;
  logic [`AXIL_ADDR_BITS-1:0]    s_axil_araddr;
  logic                          s_axil_arvalid;
  logic                          s_axil_arready;
  logic [`AXIL_DATA_BITS-1:0]    s_axil_rdata;
  logic [1:0]                    s_axil_rresp;
  logic                          s_axil_rvalid;
  logic                          s_axil_rready;
  logic                          tx_valid;
  logic [`STREAM_BITS-1:0]       tx_data;
  logic                          tx_last;
  logic                          rx_valid;
  logic [`STREAM_BITS-1:0]       rx_data;
  logic                          rx_last;

  int            errors;
  int            tx_count;     // tx words since the last start
  logic [31:0]   lfsr_state;
  logic [`STREAM_BITS:0] exp_tx;

  // configuration of the current run, as written to the DUT
  int            cfg_conn;
  int            cfg_pkg;
  logic [31:0]   cfg_port;
  logic [31:0]   cfg_ip;
  logic [31:0]   cfg_use_ip;
  logic [31:0]   cfg_xfer;
  logic [31:0]   cfg_time;

  send_recv_top DUT (.*);

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  // --------------------------------------------------------------------------
  // random numbers and reference model
  // --------------------------------------------------------------------------

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // k-th tx word of a client run, tx_last in the top bit
  function automatic logic [`STREAM_BITS:0] expect_word(input int k);
    send_recv_stream_pkg::stream_word_u w;
    int j;
    int p;
    int pos;
    int c;
    int len;
    w   = '0;
    p   = 0;
    pos = 0;
    if (k < cfg_conn) begin
      c   = k;  // open header
      len = 0;
    end else begin
      j   = k - cfg_conn;
      p   = j / (cfg_pkg + 1);
      pos = j % (cfg_pkg + 1);
      c   = p % cfg_conn;
      len = cfg_pkg * 8;
    end
    if (pos == 0) begin
      w.hdr.ip   = (cfg_use_ip != 0) ? cfg_ip + c : cfg_ip;
      w.hdr.port = cfg_port[15:0] + 16'(c);
      w.hdr.len  = 16'(len);
    end else begin
      w.payload = p * cfg_pkg + pos - 1;  // running payload index
    end
    return {(k >= cfg_conn) && (pos == cfg_pkg), w};
  endfunction

  // tx monitor
  always @(negedge aclk) begin
    if (aresetn && tx_valid) begin
      exp_tx = expect_word(tx_count);
      if (tx_data !== exp_tx[`STREAM_BITS-1:0]) begin
        $display("Error: tx_data word %0d is %h, expected %h", tx_count, tx_data,
                 exp_tx[`STREAM_BITS-1:0]);
        errors++;
      end
      if (tx_last !== exp_tx[`STREAM_BITS]) begin
        $display("Error: tx_last word %0d is %h, expected %h", tx_count, tx_last,
                 exp_tx[`STREAM_BITS]);
        errors++;
      end
      tx_count++;
    end else if (tx_last !== 1'b0) begin
      $display("tx_last was high without tx_valid");
      errors++;
    end
  end

  // --------------------------------------------------------------------------
  // axi4-lite access
  // --------------------------------------------------------------------------

  task automatic axil_write(input int idx, input logic [31:0] data, input logic [3:0] strb);
    int n;
    s_axil_awaddr  = idx << 2;
    s_axil_wdata   = data;
    s_axil_wstrb   = strb;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    s_axil_bready  = 1'b1;
    n = 0;
    @(negedge aclk);
    while (!(s_axil_awready && s_axil_wready) && n < HS_LIMIT) begin
      @(negedge aclk);
      n++;
    end
    if (!s_axil_awready || !s_axil_wready) begin
      $display("write to register %0d was never accepted", idx);
      errors++;
    end
    @(negedge aclk);  // write landed on the edge before
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    if (s_axil_bvalid !== 1'b1 || s_axil_bresp !== send_recv_axil_pkg::RESP_OKAY) begin
      $display("write to register %0d got no OKAY response", idx);
      errors++;
    end
    @(negedge aclk);
    s_axil_bready = 1'b0;
  endtask

  task automatic axil_read(input int idx, output logic [31:0] data);
    int n;
    s_axil_araddr  = idx << 2;
    s_axil_arvalid = 1'b1;
    n = 0;
    @(negedge aclk);
    while (!s_axil_arready && n < HS_LIMIT) begin
      @(negedge aclk);
      n++;
    end
    if (!s_axil_arready) begin
      $display("read of register %0d was never accepted", idx);
      errors++;
    end
    @(negedge aclk);
    s_axil_arvalid = 1'b0;
    if (s_axil_rvalid !== 1'b1 || s_axil_rresp !== send_recv_axil_pkg::RESP_OKAY) begin
      $display("read of register %0d returned no OKAY data", idx);
      errors++;
    end
    data          = s_axil_rdata;
    s_axil_rready = 1'b1;
    @(negedge aclk);
    s_axil_rready = 1'b0;
  endtask

  task automatic check_reg(input int idx, input logic [31:0] exp, input string name);
    logic [31:0] v;
    axil_read(idx, v);
    if (v !== exp) begin
      $display("Error: %s is %h, expected %h", name, v, exp);
      errors++;
    end
  endtask

  task automatic wait_done();
    logic [31:0] v;
    int          n;
    n = 0;
    v = '0;
    while (!v[0] && n < DONE_POLLS) begin
      axil_read(send_recv_axil_pkg::REG_STATUS, v);
      n++;
    end
    if (!v[0]) begin
      $display("run never set done");
      errors++;
    end
  endtask

  task automatic write_config(input logic [31:0] server);
    axil_write(send_recv_axil_pkg::REG_USE_CONN, cfg_conn, 4'hf);
    axil_write(send_recv_axil_pkg::REG_USE_IP, cfg_use_ip, 4'hf);
    axil_write(send_recv_axil_pkg::REG_PKG_WORDS, cfg_pkg, 4'hf);
    axil_write(send_recv_axil_pkg::REG_BASE_PORT, cfg_port, 4'hf);
    axil_write(send_recv_axil_pkg::REG_BASE_IP, cfg_ip, 4'hf);
    axil_write(send_recv_axil_pkg::REG_XFER_SIZE, cfg_xfer, 4'hf);
    axil_write(send_recv_axil_pkg::REG_IS_SERVER, server, 4'hf);
    axil_write(send_recv_axil_pkg::REG_TIME_CYC, cfg_time, 4'hf);
  endtask

  task automatic start_run();
    tx_count = 0;  // tx is idle here
    axil_write(send_recv_axil_pkg::REG_CTRL, 32'd1, 4'h1);
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------

  task automatic check_idle();
    check_reg(send_recv_axil_pkg::REG_STATUS, 0, "status");
    check_reg(send_recv_axil_pkg::REG_EXEC_CYC, 0, "execution_cycles");
    check_reg(send_recv_axil_pkg::REG_CONSUMED, 0, "consumed_bytes");
    check_reg(send_recv_axil_pkg::REG_PRODUCED, 0, "produced_bytes");
    check_reg(send_recv_axil_pkg::REG_OPEN_CYC, 0, "open_con_cycles");
    if (tx_count != 0) begin
      $display("tx_valid was seen after reset");
      errors++;
    end
  endtask

  task automatic check_registers();
    logic [31:0] exp_regs [2:10];
    logic [31:0] val;
    logic [3:0]  strb;
    for (int r = 2; r <= 10; r++) begin
      exp_regs[r] = '0;
    end
    repeat (2) begin
      for (int r = 2; r <= 10; r++) begin
        val  = rand_bits(32);
        strb = rand_bits(4);
        axil_write(r, val, strb);
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) begin
            exp_regs[r][b*8 +: 8] = val[b*8 +: 8];
          end
        end
      end
    end
    for (int r = 2; r <= 10; r++) begin
      check_reg(r, exp_regs[r], $sformatf("register %0d", r));
    end
    // live counters ignore writes
    for (int r = 11; r <= 14; r++) begin
      axil_write(r, rand_bits(32), 4'hf);
      check_reg(r, 0, $sformatf("register %0d", r));
    end
    check_reg(15, 0, "unused register 15");
  endtask

  task automatic client_run();
    int packets;
    int words;
    cfg_conn   = 1 + rand_bits(2);
    cfg_pkg    = 1 + rand_bits(2);
    cfg_port   = rand_bits(16);
    cfg_ip     = rand_bits(32);
    cfg_use_ip = rand_bits(1);
    cfg_xfer   = (1 + rand_bits(5)) * 8;
    cfg_time   = 0;
    write_config(0);
    start_run();
    wait_done();
    packets = (cfg_xfer + cfg_pkg * 8 - 1) / (cfg_pkg * 8);
    words   = cfg_conn + packets * (cfg_pkg + 1);
    if (tx_count != words) begin
      $display("Error: tx word count is %h, expected %h", tx_count, words);
      errors++;
    end
    check_reg(send_recv_axil_pkg::REG_PRODUCED, packets * cfg_pkg * 8, "produced_bytes");
    check_reg(send_recv_axil_pkg::REG_OPEN_CYC, cfg_conn, "open_con_cycles");
    check_reg(send_recv_axil_pkg::REG_EXEC_CYC, words, "execution_cycles");
  endtask

  task automatic server_run();
    int sent;
    int n;
    send_recv_stream_pkg::stream_word_u hdr;
    cfg_xfer = (1 + rand_bits(5)) * 8;
    cfg_time = 0;
    write_config(1);
    start_run();
    repeat (2) @(negedge aclk);
    sent = 0;
    while (sent < cfg_xfer) begin
      n            = rand_bits(3);  // 0 sends a bare connection open header
      hdr.hdr.ip   = rand_bits(32);
      hdr.hdr.port = rand_bits(16);
      hdr.hdr.len  = 16'(n * 8);
      rx_valid     = 1'b1;
      rx_data      = hdr;
      rx_last      = 1'b0;
      @(negedge aclk);
      for (int i = 0; i < n && sent < cfg_xfer; i++) begin
        rx_data = {rand_bits(32), rand_bits(32)};
        rx_last = (i == n - 1);
        @(negedge aclk);
        sent += 8;
      end
    end
    // words after done are not counted
    rx_last = 1'b0;
    repeat (2) begin
      rx_data = {rand_bits(32), rand_bits(32)};
      @(negedge aclk);
    end
    rx_valid = 1'b0;
    wait_done();
    check_reg(send_recv_axil_pkg::REG_CONSUMED, sent, "consumed_bytes");
    if (tx_count != 0) begin
      $display("tx_valid was seen during the server run");
      errors++;
    end
  endtask

  task automatic limit_run();
    cfg_time = cfg_conn + 3 + rand_bits(3);
    cfg_xfer = 32'h0010_0000;  // far beyond the limit
    write_config(0);
    start_run();
    wait_done();
    if (tx_count != cfg_time) begin
      $display("Error: tx word count is %h, expected %h", tx_count, cfg_time);
      errors++;
    end
    check_reg(send_recv_axil_pkg::REG_EXEC_CYC, cfg_time, "execution_cycles");
  endtask

  initial begin
    aresetn        = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    rx_valid       = 1'b0;
    rx_data        = '0;
    rx_last        = 1'b0;
    errors         = 0;
    tx_count       = 0;
    lfsr_state     = 32'd87;
    cfg_conn       = 1;
    cfg_pkg        = 1;
    cfg_port       = '0;
    cfg_ip         = '0;
    cfg_use_ip     = '0;
    cfg_xfer       = '0;
    cfg_time       = '0;
    repeat (RESET_CYCLES) @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);

    check_idle();
    check_registers();
    client_run();
    server_run();
    limit_run();

    $display("checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TEST_CYCLES * 4 * CLK_PERIOD);
    $display("watchdog expired, the tests did not finish in %0d cycles", TEST_CYCLES * 4);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+source
source/send_recv_axil_pkg.sv
source/send_recv_stream_pkg.sv
source/send_recv_slave.sv
source/send_recv_ctrl.sv
source/send_recv_sender.sv
source/send_recv_receiver.sv
source/send_recv_top.sv
dv/send_recv_chk.sv
dv/send_recv_tb.sv

// ==== Bender.yml ====
package:
  name: send_recv

sources:
  - include_dirs:
      - source
    files:
      - source/send_recv_axil_pkg.sv
      - source/send_recv_stream_pkg.sv
      - source/send_recv_slave.sv
      - source/send_recv_ctrl.sv
      - source/send_recv_sender.sv
      - source/send_recv_receiver.sv
      - source/send_recv_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/send_recv_chk.sv
      - dv/send_recv_tb.sv
